// ==== compile.f ====
+incdir+hw
hw/snakeGeomPkg.sv
hw/snakeCtrlPkg.sv
hw/gameControl.sv
hw/headStepper.sv
hw/snakeBody.sv
hw/collisionDetector.sv
hw/appleSpawner.sv
hw/snakeGameTop.sv
testbench/snakeGame_assert.sv
testbench/snakeGameTb.sv

// ==== testbench/snakeGameTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snakeGame_settings.svh"

module snakeGameTb;
    import snakeGeomPkg::*;
    import snakeCtrlPkg::*;

    // tick budget per test phase
    localparam int reversalTicks = 3;
    localparam int borderMaxTicks = 16;
    localparam int deadTicks = 3;
    localparam int squareTicks = 3;
    localparam int appleChases = 3;
    localparam int chaseMaxTicks = 40;
    localparam int randomTicks = 150;
    localparam int tickBudget = reversalTicks + borderMaxTicks + deadTicks + squareTicks
                              + appleChases * chaseMaxTicks + randomTicks;
    localparam int cycleLimit = tickBudget * 6 + 200;

    logic   clk;
    logic   nrst;
    logic   start;
    logic   tick;
    dirT    dir;
    pointT  head;
    pointT  apple;
    lengthT length;
    logic   playing;
    logic   ateApple;
    logic   gameOver;

    // reference model state
    pointT  modelBody[$];
    int     modelLen;
    dirT    modelHeading;
    logic   modelPlaying;
    int     eatCount;

    // expected values for the compare process
    pointT  expHead;
    lengthT expLen;
    logic   expAte;
    logic   expOver;
    logic   expPlaying;

    int          errCount;
    int          cycleCount;
    integer      seed;
    logic [31:0] r;
    dirT         req;
    int          steps;
    int          eatenBefore;

    snakeGameTop UUT (
        .clk(clk), .nrst(nrst), .start(start), .tick(tick), .dir(dir),
        .head(head), .apple(apple), .length(length),
        .playing(playing), .ateApple(ateApple), .gameOver(gameOver)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic failRun();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compareVal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            errCount++;
            $display("ERR %s: got 0x%0h expected 0x%0h", name, got, exp);
            failRun();
        end
    endtask

    function automatic dirT oppositeOf(input dirT d);
        case (d)
            dirUp:    return dirDown;
            dirDown:  return dirUp;
            dirLeft:  return dirRight;
            default:  return dirLeft;
        endcase
    endfunction

    // up lowers y, right raises x, 4-bit wrap
    function automatic pointT stepPoint(input pointT p, input dirT d);
        pointT n;
        n = p;
        case (d)
            dirUp:    n.y = p.y - 4'd1;
            dirRight: n.x = p.x + 4'd1;
            dirDown:  n.y = p.y + 4'd1;
            default:  n.x = p.x - 4'd1;
        endcase
        return n;
    endfunction

    // expected outcome of one step from the model body
    function automatic void predictStep(input dirT heading, input dirT want,
            input pointT target, output dirT newHeading, output pointT nextCell,
            output logic grows, output logic dies);
        logic selfHit;
        logic borderHit;
        newHeading = (want == oppositeOf(heading)) ? heading : want;
        nextCell = stepPoint(modelBody[0], newHeading);
        // tail slot counts as body too
        selfHit = 1'b0;
        foreach (modelBody[i]) begin
            if (modelBody[i] == nextCell) selfHit = 1'b1;
        end
        borderHit = (nextCell.x == `SNAKE_GRID_MIN) || (nextCell.x == `SNAKE_GRID_MAX)
                 || (nextCell.y == `SNAKE_GRID_MIN) || (nextCell.y == `SNAKE_GRID_MAX);
        dies = borderHit || selfHit;
        grows = !dies && (nextCell == target);
    endfunction

    // greedy walk, x first, sidestep a reversal
    function automatic dirT steerToward(input pointT target);
        pointT h;
        dirT   want;
        h = modelBody[0];
        if (h.x != target.x) want = (target.x > h.x) ? dirRight : dirLeft;
        else want = (target.y > h.y) ? dirDown : dirUp;
        if (want == oppositeOf(modelHeading)) begin
            if (want == dirLeft || want == dirRight) want = (h.y > 4'd7) ? dirUp : dirDown;
            else want = (h.x > 4'd7) ? dirLeft : dirRight;
        end
        return want;
    endfunction

    task automatic resetModel();
        pointT p;
        modelBody.delete();
        // flat snake trailing left of the head
        for (int i = 0; i < int'(`SNAKE_START_LEN); i++) begin
            p.y = `SNAKE_START_Y;
            p.x = `SNAKE_START_X - 4'(i);
            modelBody.push_back(p);
        end
        modelLen = int'(`SNAKE_START_LEN);
        modelHeading = dirRight;
        modelPlaying = 1'b1;
    endtask

    // enters and leaves on a falling edge
    task automatic startGame();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        resetModel();
        compareVal("playing", playing, 1);
        compareVal("head", head, modelBody[0]);
        compareVal("length", length, modelLen);
    endtask

    // one tick, next tick 4 cycles later
    task automatic doStep(input dirT want);
        dirT   newHeading;
        pointT nextCell;
        logic  grows;
        logic  dies;
        dir = want;
        predictStep(modelHeading, want, apple, newHeading, nextCell, grows, dies);
        expHead = modelBody[0];
        expLen = lengthT'(modelLen);
        expAte = 1'b0;
        expOver = 1'b0;
        expPlaying = modelPlaying;
        if (modelPlaying) begin
            expOver = dies;
            expPlaying = !dies;
            if (!dies) begin
                expHead = nextCell;
                expAte = grows;
                if (grows && modelLen < `SNAKE_MAX_LEN) expLen = lengthT'(modelLen + 1);
            end
        end
        tick = 1'b1;
        @(negedge clk);
        tick = 1'b0;
        // compare process samples on the second of these
        repeat (3) @(negedge clk);
        if (modelPlaying) begin
            modelHeading = newHeading;
            if (dies) begin
                modelPlaying = 1'b0;
            end else begin
                modelBody.push_front(nextCell);
                if (grows) eatCount++;
                modelLen = int'(expLen);
                while (modelBody.size() > modelLen) modelBody.delete(modelBody.size() - 1);
            end
        end
    endtask

    // results are stable two edges after the tick edge
    always begin
        @(posedge clk);
        while (tick !== 1'b1) @(posedge clk);
        @(posedge clk);
        @(posedge clk);
        @(negedge clk);
        compareVal("head", head, expHead);
        compareVal("length", length, expLen);
        compareVal("ateApple", ateApple, expAte);
        compareVal("gameOver", gameOver, expOver);
        compareVal("playing", playing, expPlaying);
        if (expAte) begin
            // fresh apple must avoid the border
            compareVal("apple.x in range", (apple.x > `SNAKE_GRID_MIN)
                       && (apple.x < `SNAKE_GRID_MAX), 1);
            compareVal("apple.y in range", (apple.y > `SNAKE_GRID_MIN)
                       && (apple.y < `SNAKE_GRID_MAX), 1);
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            failRun();
        end
    end

    initial begin
        nrst = 1'b0;
        start = 1'b0;
        tick = 1'b0;
        dir = dirRight;
        seed = 71325;
        errCount = 0;
        cycleCount = 0;
        eatCount = 0;
        resetModel();
        repeat (10) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;

        // idle after reset
        compareVal("playing", playing, 0);
        compareVal("ateApple", ateApple, 0);
        compareVal("gameOver", gameOver, 0);
        compareVal("head", head, modelBody[0]);
        compareVal("length", length, `SNAKE_START_LEN);
        startGame();

        // left and down are reversals here
        doStep(dirLeft);
        doStep(dirUp);
        doStep(dirDown);

        // straight into the right wall
        steps = 0;
        while (modelPlaying && steps < borderMaxTicks) begin
            doStep(dirRight);
            steps++;
        end
        compareVal("playing", playing, 0);
        // dead game drops ticks
        for (int i = 0; i < deadTicks; i++) begin
            r = $random(seed);
            doStep(dirT'(r[1:0]));
        end
        startGame();

        // up, left, down bites the tail
        doStep(dirUp);
        doStep(dirLeft);
        doStep(dirDown);
        compareVal("playing", playing, 0);

        // chase the apple the DUT shows
        startGame();
        for (int a = 0; a < appleChases; a++) begin
            eatenBefore = eatCount;
            steps = 0;
            while (eatCount == eatenBefore && steps < chaseMaxTicks) begin
                if (!modelPlaying) startGame();
                doStep(steerToward(apple));
                steps++;
            end
        end
        if (eatCount == 0) begin
            $display("apple chase never reached the apple");
            failRun();
        end

        // mostly straight, a turn one time in four
        for (int k = 0; k < randomTicks; k++) begin
            if (!modelPlaying) startGame();
            r = $random(seed);
            req = (r[3:2] == 2'b00) ? dirT'(r[1:0]) : modelHeading;
            doStep(req);
        end

        if (errCount == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            failRun();
        end
    end

endmodule

`default_nettype wire

// ==== testbench/snakeGame_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snakeGame_settings.svh"

module snakeGameAssert (
    input wire logic                 clk,
    input wire logic                 nrst,
    input wire logic                 playing,
    input wire logic                 ateApple,
    input wire logic                 gameOver,
    input wire snakeGeomPkg::pointT  head,
    input wire snakeCtrlPkg::lengthT length
);
    import snakeGeomPkg::*;
    import snakeCtrlPkg::*;

    // good and bad outcome are exclusive per step
    pulsesExclusive: assert property (@(posedge clk) disable iff (!nrst)
        !(ateApple && gameOver))
        else $error("ateApple and gameOver high in the same cycle");

    // game is already stopped once gameOver shows
    stopAfterOver: assert property (@(posedge clk) disable iff (!nrst)
        gameOver |=> !playing)
        else $error("playing still high after gameOver");

    lengthCeiling: assert property (@(posedge clk) disable iff (!nrst)
        length <= lengthT'(`SNAKE_MAX_LEN))
        else $error("length above the segment limit");

    // committed head never lands on a border cell
    headInside: assert property (@(posedge clk) disable iff (!nrst)
        playing |-> (head.x > `SNAKE_GRID_MIN) && (head.x < `SNAKE_GRID_MAX)
                 && (head.y > `SNAKE_GRID_MIN) && (head.y < `SNAKE_GRID_MAX))
        else $error("head outside the grid limits while playing");

endmodule

bind snakeGameTop snakeGameAssert gameChecks (
    .clk(clk), .nrst(nrst), .playing(playing), .ateApple(ateApple),
    .gameOver(gameOver), .head(head), .length(length)
);

`default_nettype wire

// ==== hw/snakeGameTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snakeGame_settings.svh"

module snakeGameTop (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 start,
    input  logic                 tick,
    input  snakeGeomPkg::dirT    dir,
    output snakeGeomPkg::pointT  head,
    output snakeGeomPkg::pointT  apple,
    output snakeCtrlPkg::lengthT length,
    output logic                 playing,
    output logic                 ateApple,
    output logic                 gameOver
);
    import snakeGeomPkg::*;
    import snakeCtrlPkg::*;

    // control strobes
    logic loadStart;
    logic stepEn;
    logic checkEnable;
    logic push;
    logic grow;
    logic respawn;

    // datapath
    stepEventsT                     events;
    pointT                          nextHead;
    pointT [`SNAKE_MAX_LEN-1:0]     segments;

    gameControl ctrl (
        .clk(clk), .nrst(nrst), .start(start), .tick(tick), .events(events),
        .loadStart(loadStart), .stepEn(stepEn), .checkEnable(checkEnable),
        .push(push), .grow(grow), .respawn(respawn),
        .playing(playing), .ateApple(ateApple), .gameOver(gameOver)
    );

    headStepper stepper (
        .clk(clk), .nrst(nrst), .loadStart(loadStart), .stepEn(stepEn),
        .dir(dir), .head(head), .nextHead(nextHead)
    );

    snakeBody #(.maxLength(`SNAKE_MAX_LEN)) body (
        .clk(clk), .nrst(nrst), .loadStart(loadStart), .push(push), .grow(grow),
        .newHead(nextHead), .segments(segments), .length(length), .head(head)
    );

    collisionDetector #(.maxLength(`SNAKE_MAX_LEN)) detector (
        .clk(clk), .nrst(nrst), .checkEnable(checkEnable), .nextHead(nextHead),
        .apple(apple), .segments(segments), .length(length), .events(events)
    );

    appleSpawner spawner (
        .clk(clk), .nrst(nrst), .loadStart(loadStart), .respawn(respawn),
        .apple(apple)
    );

endmodule

`default_nettype wire

// ==== hw/appleSpawner.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snakeGame_settings.svh"

module appleSpawner (
    input  logic               clk,
    input  logic               nrst,
    input  logic               loadStart,
    input  logic               respawn,
    output snakeGeomPkg::pointT apple
);
    import snakeGeomPkg::*;

    logic [7:0] lfsr;
    logic       feedback;

    // keep the apple off the border cells
    function automatic coordT clampCoord(input coordT c);
        if (c <= `SNAKE_GRID_MIN) begin
            clampCoord = `SNAKE_GRID_MIN + 4'd1;
        end else if (c >= `SNAKE_GRID_MAX) begin
            clampCoord = `SNAKE_GRID_MAX - 4'd1;
        end else begin
            clampCoord = c;
        end
    endfunction

    // taps 8,6,5,4 give the full 255-state cycle
    assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            lfsr <= `SNAKE_LFSR_SEED;
        end else begin
            lfsr <= {lfsr[6:0], feedback};
        end
    end

    // x from low nibble, y from high nibble
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            apple.x <= clampCoord(coordT'(`SNAKE_LFSR_SEED & 8'h0F));
            apple.y <= clampCoord(coordT'(`SNAKE_LFSR_SEED >> 4));
        end else if (loadStart || respawn) begin
            apple.x <= clampCoord(lfsr[3:0]);
            apple.y <= clampCoord(lfsr[7:4]);
        end
    end

endmodule

`default_nettype wire

// ==== hw/collisionDetector.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snakeGame_settings.svh"

module collisionDetector #(
    parameter int maxLength = `SNAKE_MAX_LEN
) (
    input  logic                                clk,
    input  logic                                nrst,
    input  logic                                checkEnable,
    input  snakeGeomPkg::pointT                 nextHead,
    input  snakeGeomPkg::pointT                 apple,
    input  snakeGeomPkg::pointT [maxLength-1:0] segments,
    input  snakeCtrlPkg::lengthT                length,
    output snakeCtrlPkg::stepEventsT            events
);
    import snakeGeomPkg::*;
    import snakeCtrlPkg::*;

    logic       borderHit;
    logic       selfHit;
    logic       appleHit;
    stepEventsT eventsNext;

    always_comb begin
        // any border cell is fatal, all four sides
        borderHit = (nextHead.x <= `SNAKE_GRID_MIN) || (nextHead.x >= `SNAKE_GRID_MAX)
                 || (nextHead.y <= `SNAKE_GRID_MIN) || (nextHead.y >= `SNAKE_GRID_MAX);

        // own body, tail slot included
        selfHit = 1'b0;
        for (int i = 0; i < maxLength; i++) begin
            if ((lengthT'(i) < length) && (segments[i] == nextHead)) begin
                selfHit = 1'b1;
            end
        end

        appleHit = (nextHead == apple);

        eventsNext.ateApple     = appleHit;
        eventsNext.hitSomething = borderHit || selfHit;
    end

    // flags only move on checkEnable, held in between
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            events <= '0;
        end else if (checkEnable) begin
            events <= eventsNext;
        end
    end

endmodule

`default_nettype wire

// ==== hw/snakeBody.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snakeGame_settings.svh"

module snakeBody #(
    parameter int maxLength = `SNAKE_MAX_LEN
) (
    input  logic                                clk,
    input  logic                                nrst,
    input  logic                                loadStart,
    input  logic                                push,
    input  logic                                grow,
    input  snakeGeomPkg::pointT                 newHead,
    output snakeGeomPkg::pointT [maxLength-1:0] segments,
    output snakeCtrlPkg::lengthT                length,
    output snakeGeomPkg::pointT                 head
);
    import snakeGeomPkg::*;
    import snakeCtrlPkg::*;

    // start snake lies flat, trailing left of the head
    // slots past the start length are don't-care
    function automatic pointT startSegment(input int idx);
        pointT p;
        p.y = `SNAKE_START_Y;
        p.x = `SNAKE_START_X - coordT'(idx);
        startSegment = p;
    endfunction

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < maxLength; i++) begin
                segments[i] <= startSegment(i);
            end
        end else if (loadStart) begin
            for (int i = 0; i < maxLength; i++) begin
                segments[i] <= startSegment(i);
            end
        end else if (push) begin
            // whole body slides one slot toward the tail
            for (int i = maxLength - 1; i > 0; i--) begin
                segments[i] <= segments[i-1];
            end
            segments[0] <= newHead;
        end
    end

    // length decides which slots count as body
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            length <= `SNAKE_START_LEN;
        end else if (loadStart) begin
            length <= `SNAKE_START_LEN;
        end else if (push && grow && (length < lengthT'(maxLength))) begin
            length <= length + 5'd1;
        end
    end

    assign head = segments[0];

endmodule

`default_nettype wire

// ==== hw/headStepper.sv ====
`timescale 1ns/1ps
`default_nettype none

module headStepper (
    input  logic               clk,
    input  logic               nrst,
    input  logic               loadStart,
    input  logic               stepEn,
    input  snakeGeomPkg::dirT   dir,
    input  snakeGeomPkg::pointT head,
    output snakeGeomPkg::pointT nextHead
);
    import snakeGeomPkg::*;

    dirT heading;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            heading <= dirRight;
        end else if (loadStart) begin
            heading <= dirRight;
        end else if (stepEn && (dir != oppositeDir(heading))) begin
            // reversal requests keep the old heading
            heading <= dir;
        end
    end

    // one cell along the heading
    // 4-bit wrap never matters, border cells kill first
    always_comb begin
        nextHead = head;
        case (heading)
            dirUp:    nextHead.y = head.y - 4'd1;
            dirRight: nextHead.x = head.x + 4'd1;
            dirDown:  nextHead.y = head.y + 4'd1;
            dirLeft:  nextHead.x = head.x - 4'd1;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/gameControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module gameControl (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    start,
    input  logic                    tick,
    input  snakeCtrlPkg::stepEventsT events,
    output logic                    loadStart,
    output logic                    stepEn,
    output logic                    checkEnable,
    output logic                    push,
    output logic                    grow,
    output logic                    respawn,
    output logic                    playing,
    output logic                    ateApple,
    output logic                    gameOver
);
    import snakeCtrlPkg::*;

    gameStateT state;
    gameStateT stateNext;
    logic      stopped;
    logic      judging;

    // strobes decoded straight from the state
    always_comb begin
        stopped     = (state == stIdle) || (state == stDead);
        judging     = (state == stJudge);
        loadStart   = stopped && start;
        stepEn      = (state == stRun) && tick;
        checkEnable = (state == stMove);
        // commit only when nothing was hit
        push        = judging && !events.hitSomething;
        grow        = push && events.ateApple;
        respawn     = grow;
        playing     = !stopped;
    end

    always_comb begin
        stateNext = state;
        case (state)
            stIdle, stDead: begin
                if (start) stateNext = stRun;
            end
            stRun: begin
                // ticks elsewhere are dropped
                if (tick) stateNext = stMove;
            end
            stMove: begin
                stateNext = stJudge;
            end
            stJudge: begin
                stateNext = events.hitSomething ? stDead : stRun;
            end
            default: begin
                stateNext = stIdle;
            end
        endcase
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state    <= stIdle;
            ateApple <= 1'b0;
            gameOver <= 1'b0;
        end else begin
            state    <= stateNext;
            // outside pulses line up with the body commit edge
            ateApple <= grow;
            gameOver <= judging && events.hitSomething;
        end
    end

endmodule

`default_nettype wire

// ==== hw/snakeCtrlPkg.sv ====
`default_nettype none

package snakeCtrlPkg;

    // step sequencer states
    // stRun waits for a tick, stMove checks, stJudge commits
    typedef enum logic [2:0] {
        stIdle  = 3'd0,
        stRun   = 3'd1,
        stMove  = 3'd2,
        stJudge = 3'd3,
        stDead  = 3'd4
    } gameStateT;

    // number of valid body segments
    typedef logic [4:0] lengthT;

    // registered outcome of one step check
    typedef struct packed {
        // good outcome when the next head lands on the apple
        logic ateApple;
        // bad outcome on a border or own body hit
        logic hitSomething;
    } stepEventsT;

endpackage

`default_nettype wire

// ==== hw/snakeGeomPkg.sv ====
`default_nettype none

package snakeGeomPkg;

    // one grid coordinate, 0..15
    typedef logic [3:0] coordT;

    // cell on the board, y in the high nibble
    typedef struct packed {
        coordT y;
        coordT x;
    } pointT;

    // heading of the snake
    // up lowers y, right raises x
    typedef enum logic [1:0] {
        dirUp    = 2'd0,
        dirRight = 2'd1,
        dirDown  = 2'd2,
        dirLeft  = 2'd3
    } dirT;

    // opposite heading, flips bit 1 of the encoding
    function automatic dirT oppositeDir(input dirT d);
        oppositeDir = dirT'(d ^ 2'b10);
    endfunction

endpackage

`default_nettype wire

// ==== hw/snakeGame_settings.svh ====
`ifndef SNAKE_GAME_SETTINGS_SVH
`define SNAKE_GAME_SETTINGS_SVH

// border cells of the 16x16 field
// a head sitting on either value is fatal
`define SNAKE_GRID_MIN 4'd0
`define SNAKE_GRID_MAX 4'd15

// body segment storage, also the length ceiling
`define SNAKE_MAX_LEN 16

// start snake, head cell and length
// body trails to the left of the head
`define SNAKE_START_X 4'd8
`define SNAKE_START_Y 4'd8
`define SNAKE_START_LEN 5'd4

// lfsr start value
// must not be zero or the lfsr locks up
`define SNAKE_LFSR_SEED 8'hA5

`endif
